// ==== common/uop_config.svh ====
// Micro-op front end configuration

`ifndef UOP_CONFIG_SVH
`define UOP_CONFIG_SVH

// ============================================================
// Fetch group shape
// ============================================================

// Instruction slots carried by one fetch group
`define UOP_MWIDTH 2

// Longest expansion of a single instruction (SWAP)
`define UOP_MAX_PER_INSTR 3

// ============================================================
// Micro-op queue shape
// ============================================================

// Queue entries, must stay a power of two so the pointers wrap freely
`define UOPQ_DEPTH 16

// Micro-ops offered to the downstream stage each cycle
`define UOP_OUT_WIDTH 2

`endif

// ==== common/uop_pkg.sv ====
// Micro-op front end types

`include "uop_config.svh"

package uop_pkg;

	// ============================================================
	// Architectural instruction format
	// ============================================================

	// Instruction opcodes, codes 8 to 15 are undefined and trap
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		LD   = 4'd3,
		ST   = 4'd4,
		PUSH = 4'd5,
		POP  = 4'd6,
		SWAP = 4'd7
	} opcode_e;

	// One 16-bit instruction
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
	} instr_t;

	// A fetch slot with its valid bit
	typedef struct packed {
		logic   valid;
		instr_t instr;
	} slot_t;

	// Slot 0 sits in the low bits of the group
	typedef slot_t [`UOP_MWIDTH-1:0] group_t;

	// ============================================================
	// Micro-op format
	// ============================================================

	typedef enum logic [3:0] {
		U_NOP   = 4'd0,
		U_ADD   = 4'd1,
		U_SUB   = 4'd2,
		U_ADDI  = 4'd3,
		U_LOAD  = 4'd4,
		U_STORE = 4'd5,
		U_MOV   = 4'd6,
		U_TRAP  = 4'd7
	} uop_op_e;

	// For stores rd names the data register and rs1 the base
	typedef struct packed {
		uop_op_e    op;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] imm;
		// First micro-op of its instruction
		logic       lead;
		// Final micro-op of its instruction
		logic       last;
	} uop_t;

	// Expansion of one instruction, entry 0 comes first
	typedef uop_t [`UOP_MAX_PER_INSTR-1:0] uop_list_t;

	// Stack pointer and scratch register used by the expansions
	localparam logic [3:0] SP_REG  = 4'd15;
	localparam logic [3:0] TMP_REG = 4'd14;

endpackage

// ==== translate/uop_rom.sv ====
// Instruction to micro-op expansion ROM

`include "uop_config.svh"

module uop_rom (
	input  uop_pkg::slot_t     slot,
	output uop_pkg::uop_list_t uops,
	output logic [1:0]         count
);

	// ============================================================
	// Expansion table
	// ============================================================

	always_comb begin
		uops  = '0;
		count = 2'd0;
		if (slot.valid) begin
			case (slot.instr.opcode)
				uop_pkg::NOP: begin
					uops[0].op = uop_pkg::U_NOP;
					count      = 2'd1;
				end
				// Register-register ALU ops carry rs2 in the imm field
				uop_pkg::ADD, uop_pkg::SUB: begin
					uops[0].op  = (slot.instr.opcode == uop_pkg::ADD) ?
						uop_pkg::U_ADD : uop_pkg::U_SUB;
					uops[0].rd  = slot.instr.rd;
					uops[0].rs1 = slot.instr.rs1;
					uops[0].imm = slot.instr.rs2;
					count       = 2'd1;
				end
				uop_pkg::LD, uop_pkg::ST: begin
					uops[0].op  = (slot.instr.opcode == uop_pkg::LD) ?
						uop_pkg::U_LOAD : uop_pkg::U_STORE;
					uops[0].rd  = slot.instr.rd;
					uops[0].rs1 = slot.instr.rs1;
					uops[0].imm = slot.instr.rs2;
					count       = 2'd1;
				end
				// Pre-decrement the stack pointer, then store through it
				uop_pkg::PUSH: begin
					uops[0].op  = uop_pkg::U_ADDI;
					uops[0].rd  = uop_pkg::SP_REG;
					uops[0].rs1 = uop_pkg::SP_REG;
					uops[0].imm = 4'd15;
					uops[1].op  = uop_pkg::U_STORE;
					uops[1].rd  = slot.instr.rd;
					uops[1].rs1 = uop_pkg::SP_REG;
					count       = 2'd2;
				end
				// Load from the top of stack, then post-increment
				uop_pkg::POP: begin
					uops[0].op  = uop_pkg::U_LOAD;
					uops[0].rd  = slot.instr.rd;
					uops[0].rs1 = uop_pkg::SP_REG;
					uops[1].op  = uop_pkg::U_ADDI;
					uops[1].rd  = uop_pkg::SP_REG;
					uops[1].rs1 = uop_pkg::SP_REG;
					uops[1].imm = 4'd1;
					count       = 2'd2;
				end
				// Three moves through the scratch register
				uop_pkg::SWAP: begin
					uops[0].op  = uop_pkg::U_MOV;
					uops[0].rd  = uop_pkg::TMP_REG;
					uops[0].rs1 = slot.instr.rd;
					uops[1].op  = uop_pkg::U_MOV;
					uops[1].rd  = slot.instr.rd;
					uops[1].rs1 = slot.instr.rs1;
					uops[2].op  = uop_pkg::U_MOV;
					uops[2].rd  = slot.instr.rs1;
					uops[2].rs1 = uop_pkg::TMP_REG;
					count       = 2'd3;
				end
				// Undefined opcodes trap and report the code in rd
				default: begin
					uops[0].op = uop_pkg::U_TRAP;
					uops[0].rd = slot.instr.opcode;
					count      = 2'd1;
				end
			endcase

			// Mark the instruction boundaries inside the list
			uops[0].lead = 1'b1;
			for (int i = 0; i < `UOP_MAX_PER_INSTR; i++)
				uops[i].last = (i == int'(count) - 1);
		end
	end

	// A valid instruction must always reach the queue as something
	always_comb
		assert final (!slot.valid || (count >= 2'd1 && count <= 2'd3));

endmodule

// ==== rtl/micro_op_queue.sv ====
// Micro-op queue

`include "uop_config.svh"

module micro_op_queue (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  uop_pkg::uop_list_t                    lists [0:`UOP_MWIDTH-1],
	input  logic [1:0]                            counts [0:`UOP_MWIDTH-1],
	output logic                                  advance,
	output uop_pkg::uop_t [`UOP_OUT_WIDTH-1:0]    out_uops,
	output logic [2:0]                            out_count
);

	localparam int PTR_W = $clog2(`UOPQ_DEPTH);
	localparam int OCC_W = PTR_W + 1;
	localparam int SUM_W = OCC_W + 1;
	// Room that must remain for the next group before fetch may advance
	localparam int NEED  = `UOP_MWIDTH * `UOP_MAX_PER_INSTR;

	// Entry storage has no reset, occupancy alone says what is live
	uop_pkg::uop_t     mem [0:`UOPQ_DEPTH-1];
	logic [PTR_W-1:0]  head;
	logic [PTR_W-1:0]  tail;
	logic [OCC_W-1:0]  occ;

	// Offset of each slot's first entry from the tail
	logic [2:0]        base [0:`UOP_MWIDTH-1];
	logic [2:0]        wr_count;
	logic [2:0]        pop_count;

	// ============================================================
	// Write side
	// ============================================================

	// Slot offsets are a running sum, so slot 1 lands right after slot 0
	always_comb begin
		wr_count = 3'd0;
		for (int s = 0; s < `UOP_MWIDTH; s++) begin
			base[s]  = wr_count;
			wr_count = wr_count + 3'(counts[s]);
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `UOP_MWIDTH; s++)
			for (int k = 0; k < `UOP_MAX_PER_INSTR; k++)
				if (k < int'(counts[s]))
					mem[tail + PTR_W'(base[s]) + PTR_W'(k)] <= lists[s][k];
	end

	// ============================================================
	// Read side
	// ============================================================

	// Show as many head entries as are live, up to the output width
	always_comb begin
		if (occ >= OCC_W'(`UOP_OUT_WIDTH))
			out_count = 3'(`UOP_OUT_WIDTH);
		else
			out_count = 3'(occ);
		for (int i = 0; i < `UOP_OUT_WIDTH; i++)
			out_uops[i] = (i < int'(out_count)) ? mem[head + PTR_W'(i)] : '0;
	end

	// Downstream takes everything shown whenever it is enabled
	assign pop_count = en ? out_count : 3'd0;

	// ============================================================
	// Pointers and occupancy
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			occ  <= '0;
		end else begin
			head <= head + PTR_W'(pop_count);
			tail <= tail + PTR_W'(wr_count);
			occ  <= occ + OCC_W'(wr_count) - OCC_W'(pop_count);
		end
	end

	// The group in the stage register is written at the next edge.
	// Whatever is left after it must still fit a full next group
	assign advance = (SUM_W'(occ) + SUM_W'(wr_count) + SUM_W'(NEED))
		<= SUM_W'(`UOPQ_DEPTH);

	// Holds only if the advance throttle upstream keeps its promise
	assert property (@(posedge clk) disable iff (rst)
		occ <= OCC_W'(`UOPQ_DEPTH));

endmodule

// ==== translate/uop_translate_stage.sv ====
// Micro-op translation stage

`include "uop_config.svh"

module uop_translate_stage (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic                                  stomp,
	input  uop_pkg::group_t                       group_in,
	output logic                                  advance,
	output uop_pkg::uop_t [`UOP_OUT_WIDTH-1:0]    out_uops,
	output logic [2:0]                            out_count
);

	// Group held for one cycle while its slots are translated
	uop_pkg::group_t   group_q;

	// Per-slot expansions and their lengths
	uop_pkg::uop_list_t lists [0:`UOP_MWIDTH-1];
	logic [1:0]         counts [0:`UOP_MWIDTH-1];

	// ============================================================
	// Group register
	// ============================================================

	// The instruction fields simply follow the input every cycle.
	// Only the valid bits decide whether the group reaches the queue
	// A group is accepted only while the queue has room for it, and
	// a stomp drops every slot of the group arriving at that edge
	always_ff @(posedge clk) begin
		for (int i = 0; i < `UOP_MWIDTH; i++) begin
			group_q[i].instr <= group_in[i].instr;
			if (rst)
				group_q[i].valid <= 1'b0;
			else
				group_q[i].valid <= group_in[i].valid & advance & ~stomp;
		end
	end

	// ============================================================
	// Translation ROMs, one per slot
	// ============================================================

	for (genvar g = 0; g < `UOP_MWIDTH; g++) begin : g_rom
		uop_rom u_rom (
			.slot  (group_q[g]),
			.uops  (lists[g]),
			.count (counts[g])
		);

		// A group presented while advance is low must never enter the queue,
		// otherwise the held group would be written twice
		assert property (@(posedge clk) disable iff (rst)
			!advance |=> !group_q[g].valid);
	end

	// Queue takes the lists in slot order and drives advance back to fetch
	micro_op_queue u_queue (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.lists     (lists),
		.counts    (counts),
		.advance   (advance),
		.out_uops  (out_uops),
		.out_count (out_count)
	);

endmodule

// ==== rtl/uop_frontend_top.sv ====
// Micro-op front end top level

`include "uop_config.svh"

module uop_frontend_top (
	input  logic                                  clk,
	input  logic                                  rst,
	// Downstream takes out_count micro-ops at each edge with en high
	input  logic                                  en,
	// Drops every slot of the group presented at this edge
	input  logic                                  stomp,
	input  uop_pkg::group_t                       group_in,
	// Fetch may present its next group while this is high
	output logic                                  advance,
	output uop_pkg::uop_t [`UOP_OUT_WIDTH-1:0]    out_uops,
	output logic [2:0]                            out_count
);

	// ============================================================
	// Translation stage
	// ============================================================

	// The stage holds the group register, the ROMs and the queue
	uop_translate_stage u_stage (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.stomp     (stomp),
		.group_in  (group_in),
		.advance   (advance),
		.out_uops  (out_uops),
		.out_count (out_count)
	);

endmodule

// ==== verif/tb_uop_frontend.sv ====
// Micro-op front end testbench

`include "uop_config.svh"

module tb_uop_frontend;

	localparam int NEED        = `UOP_MWIDTH * `UOP_MAX_PER_INSTR;
	localparam int WAIT_LIMIT  = 200;
	localparam int DRAIN_LIMIT = 400;

	logic                                 clk;
	logic                                 rst;
	logic                                 en;
	logic                                 stomp;
	uop_pkg::group_t                      group_in;
	logic                                 advance;
	uop_pkg::uop_t [`UOP_OUT_WIDTH-1:0]   out_uops;
	logic [2:0]                           out_count;

	// Micro-ops already written into the DUT queue in order from the head
	uop_pkg::uop_t exp_q [$];
	// Micro-ops of the group now held in the stage register
	uop_pkg::uop_t stage_q [$];

	string  test_name = "reset";
	integer seed = 32'heae83ac7;
	// Lets the waits toggle en at random during the stream test
	bit     en_random = 1'b0;

	uop_frontend_top dut (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.stomp     (stomp),
		.group_in  (group_in),
		.advance   (advance),
		.out_uops  (out_uops),
		.out_count (out_count)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ============================================================
	// Failure reporting and compare tasks
	// ============================================================

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_uop(input string what, input uop_pkg::uop_t exp,
		input uop_pkg::uop_t act);
		if (exp !== act)
			stop_run($sformatf("Error in %s (%s): expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_count(input string what, input logic [2:0] exp, input logic [2:0] act);
		if (exp !== act)
			stop_run($sformatf("Error in %s (%s): expected %0d, actual %0d",
				test_name, what, exp, act));
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		if (exp !== act)
			stop_run($sformatf("Error in %s (%s): expected %b, actual %b",
				test_name, what, exp, act));
	endtask

	// ============================================================
	// Reference expansion
	// ============================================================

	function automatic uop_pkg::uop_t make_uop(input uop_pkg::uop_op_e op,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] imm);
		uop_pkg::uop_t u;
		u      = '0;
		u.op   = op;
		u.rd   = rd;
		u.rs1  = rs1;
		u.imm  = imm;
		return u;
	endfunction

	function automatic uop_pkg::slot_t make_slot(input logic v, input logic [3:0] op,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2);
		uop_pkg::slot_t s;
		s.valid        = v;
		s.instr.opcode = uop_pkg::opcode_e'(op);
		s.instr.rd     = rd;
		s.instr.rs1    = rs1;
		s.instr.rs2    = rs2;
		return s;
	endfunction

	// Appends one slot's micro-ops to the staged group
	function automatic void stage_slot(input uop_pkg::slot_t s);
		uop_pkg::uop_t seq [0:2];
		uop_pkg::uop_t u;
		int            n;
		logic [3:0]    rd;
		logic [3:0]    rs1;
		logic [3:0]    rs2;
		rd  = s.instr.rd;
		rs1 = s.instr.rs1;
		rs2 = s.instr.rs2;
		n   = 1;
		if (!s.valid)
			return;
		case (s.instr.opcode)
			uop_pkg::NOP:  seq[0] = make_uop(uop_pkg::U_NOP, 4'd0, 4'd0, 4'd0);
			uop_pkg::ADD:  seq[0] = make_uop(uop_pkg::U_ADD, rd, rs1, rs2);
			uop_pkg::SUB:  seq[0] = make_uop(uop_pkg::U_SUB, rd, rs1, rs2);
			uop_pkg::LD:   seq[0] = make_uop(uop_pkg::U_LOAD, rd, rs1, rs2);
			uop_pkg::ST:   seq[0] = make_uop(uop_pkg::U_STORE, rd, rs1, rs2);
			uop_pkg::PUSH: begin
				seq[0] = make_uop(uop_pkg::U_ADDI, uop_pkg::SP_REG, uop_pkg::SP_REG, 4'd15);
				seq[1] = make_uop(uop_pkg::U_STORE, rd, uop_pkg::SP_REG, 4'd0);
				n      = 2;
			end
			uop_pkg::POP: begin
				seq[0] = make_uop(uop_pkg::U_LOAD, rd, uop_pkg::SP_REG, 4'd0);
				seq[1] = make_uop(uop_pkg::U_ADDI, uop_pkg::SP_REG, uop_pkg::SP_REG, 4'd1);
				n      = 2;
			end
			uop_pkg::SWAP: begin
				seq[0] = make_uop(uop_pkg::U_MOV, uop_pkg::TMP_REG, rd, 4'd0);
				seq[1] = make_uop(uop_pkg::U_MOV, rd, rs1, 4'd0);
				seq[2] = make_uop(uop_pkg::U_MOV, rs1, uop_pkg::TMP_REG, 4'd0);
				n      = 3;
			end
			default: seq[0] = make_uop(uop_pkg::U_TRAP, s.instr.opcode, 4'd0, 4'd0);
		endcase
		for (int k = 0; k < n; k++) begin
			u      = seq[k];
			u.lead = (k == 0);
			u.last = (k == n - 1);
			stage_q.push_back(u);
		end
	endfunction

	// ============================================================
	// Scoreboard sampled at the falling edge where all levels are settled
	// ============================================================

	always @(negedge clk) begin : model_check
		int   shown;
		logic exp_adv;
		if (rst) begin
			exp_q.delete();
			stage_q.delete();
		end else begin
			// Free entries left once the staged group lands must hold a full group
			exp_adv = (`UOPQ_DEPTH - exp_q.size() - stage_q.size()) >= NEED;
			check_level("advance", exp_adv, advance);
			shown = (exp_q.size() < `UOP_OUT_WIDTH) ? exp_q.size() : `UOP_OUT_WIDTH;
			check_count("out_count", 3'(shown), out_count);
			for (int i = 0; i < shown; i++)
				check_uop("out_uops", exp_q[i], out_uops[i]);
			// The coming edge pops what is shown, writes the staged group
			// and may accept the group on the inputs
			if (en)
				for (int i = 0; i < shown; i++)
					void'(exp_q.pop_front());
			while (stage_q.size() > 0)
				exp_q.push_back(stage_q.pop_front());
			if (advance && !stomp)
				for (int s = 0; s < `UOP_MWIDTH; s++)
					stage_slot(group_in[s]);
		end
	end

	// ============================================================
	// Drive and wait helpers
	// ============================================================

	task automatic pick_en();
		integer rnd;
		if (en_random) begin
			rnd = $random(seed);
			en <= rnd[0];
		end
	endtask

	// Returns at a falling edge with advance high
	task automatic wait_advance();
		int tries;
		tries = 0;
		@(negedge clk);
		while (!advance) begin
			tries++;
			if (tries > WAIT_LIMIT)
				stop_run($sformatf("Timeout in %s: advance stayed low", test_name));
			@(posedge clk);
			pick_en();
			@(negedge clk);
		end
	endtask

	// Holds a group until it is accepted and returns at the accepting edge
	task automatic drive_group(input uop_pkg::slot_t s0, input uop_pkg::slot_t s1,
		input logic stomp_v);
		group_in <= {s1, s0};
		stomp    <= stomp_v;
		pick_en();
		wait_advance();
		@(posedge clk);
		group_in <= '0;
		stomp    <= 1'b0;
	endtask

	task automatic wait_out(input int n);
		int tries;
		tries = 0;
		@(negedge clk);
		while (int'(out_count) < n) begin
			tries++;
			if (tries > WAIT_LIMIT)
				stop_run($sformatf("Timeout in %s: micro-ops never appeared", test_name));
			@(negedge clk);
		end
	endtask

	// Model queues only change at falling edges, so they are read at rising ones
	task automatic wait_drain();
		int tries;
		tries = 0;
		@(posedge clk);
		while (exp_q.size() != 0 || stage_q.size() != 0) begin
			tries++;
			if (tries > DRAIN_LIMIT)
				stop_run($sformatf("Timeout in %s: queue did not drain", test_name));
			@(posedge clk);
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic reset_and_alu();
		test_name = "reset_alu";
		@(negedge clk);
		check_level("advance after reset", 1'b1, advance);
		check_count("out_count after reset", 3'd0, out_count);
		@(posedge clk);
		en <= 1'b0;
		drive_group(make_slot(1'b1, 4'd1, 4'd1, 4'd2, 4'd3),
			make_slot(1'b1, 4'd2, 4'd4, 4'd5, 4'd6), 1'b0);
		wait_out(2);
		check_uop("slot 0", '{uop_pkg::U_ADD, 4'd1, 4'd2, 4'd3, 1'b1, 1'b1}, out_uops[0]);
		check_uop("slot 1", '{uop_pkg::U_SUB, 4'd4, 4'd5, 4'd6, 1'b1, 1'b1}, out_uops[1]);
		@(posedge clk);
		en <= 1'b1;
		wait_drain();
	endtask

	task automatic expand_opcodes();
		test_name = "expansion";
		en <= 1'b1;
		drive_group(make_slot(1'b1, 4'd5, 4'd3, 4'd0, 4'd0),
			make_slot(1'b1, 4'd6, 4'd4, 4'd0, 4'd0), 1'b0);
		drive_group(make_slot(1'b1, 4'd7, 4'd1, 4'd2, 4'd0),
			make_slot(1'b1, 4'd3, 4'd5, 4'd6, 4'd7), 1'b0);
		drive_group(make_slot(1'b1, 4'd4, 4'd8, 4'd9, 4'd2),
			make_slot(1'b1, 4'hb, 4'd0, 4'd0, 4'd0), 1'b0);
		wait_drain();
	endtask

	task automatic drop_invalid_slots();
		test_name = "invalid_stomp";
		drive_group(make_slot(1'b0, 4'd7, 4'd1, 4'd2, 4'd0),
			make_slot(1'b1, 4'd1, 4'd3, 4'd4, 4'd5), 1'b0);
		drive_group(make_slot(1'b1, 4'd7, 4'd6, 4'd7, 4'd0),
			make_slot(1'b1, 4'd5, 4'd2, 4'd0, 4'd0), 1'b1);
		drive_group(make_slot(1'b1, 4'd6, 4'd9, 4'd0, 4'd0),
			make_slot(1'b1, 4'd2, 4'd1, 4'd1, 4'd1), 1'b0);
		wait_drain();
	endtask

	task automatic stall_and_drain();
		int groups;
		test_name = "backpressure";
		groups    = 0;
		en       <= 1'b0;
		group_in <= {make_slot(1'b1, 4'd7, 4'd2, 4'd3, 4'd0),
			make_slot(1'b1, 4'd7, 4'd0, 4'd1, 4'd0)};
		@(negedge clk);
		while (advance) begin
			groups++;
			if (groups > 10)
				stop_run("Advance never fell while the queue was held by back-pressure");
			@(posedge clk);
			group_in <= {make_slot(1'b1, 4'd7, 4'(groups), 4'd3, 4'd0),
				make_slot(1'b1, 4'd7, 4'd0, 4'(groups), 4'd0)};
			@(negedge clk);
		end
		repeat (3) begin
			@(negedge clk);
			check_level("advance while stalled", 1'b0, advance);
		end
		@(posedge clk);
		en <= 1'b1;
		wait_advance();
		@(posedge clk);
		group_in <= '0;
		wait_drain();
		@(negedge clk);
		check_level("advance after drain", 1'b1, advance);
	endtask

	task automatic random_stream();
		integer         rnd;
		uop_pkg::slot_t s0;
		uop_pkg::slot_t s1;
		test_name = "random_stream";
		// The previous test ended at a falling edge and inputs change only at rising ones
		@(posedge clk);
		en_random = 1'b1;
		for (int g = 0; g < 200; g++) begin
			rnd = $random(seed);
			s0  = uop_pkg::slot_t'(rnd[16:0]);
			rnd = $random(seed);
			s1  = uop_pkg::slot_t'(rnd[16:0]);
			rnd = $random(seed);
			drive_group(s0, s1, rnd[2:0] == 3'd0);
		end
		en_random = 1'b0;
		en       <= 1'b1;
		wait_drain();
	endtask

	initial begin
		rst      <= 1'b1;
		en       <= 1'b1;
		stomp    <= 1'b0;
		group_in <= '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		reset_and_alu();
		expand_opcodes();
		drop_invalid_slots();
		stall_and_drain();
		random_stream();
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+common
common/uop_pkg.sv
translate/uop_rom.sv
rtl/micro_op_queue.sv
translate/uop_translate_stage.sv
rtl/uop_frontend_top.sv
verif/tb_uop_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_uop_frontend \
	-Mdir obj_dir \
	-f flist.f

./obj_dir/Vtb_uop_frontend
